/* hdl/rvPkg.sv */
package rvPkg;

	localparam int xlen  = 32;
	localparam int addrW = 12;  // byte addr on imem, word addr on dmem

	// halt pair, addi x1,x0,12 then jalr x0,0(x1)
	localparam logic [31:0] haltInstr0 = 32'h00c00093;
	localparam logic [31:0] haltInstr1 = 32'h00008067;

	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opOpImm  = 7'b0010011;
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;

	// instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sType_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		logic [6:0] opcode;
	} bType_t;

	typedef struct packed {
		logic [19:0] imm;  // bits 31..12 of the result
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uType_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jType_t;

	// one fetched word, several field layouts
	typedef union packed {
		rType_t      rType;
		iType_t      iType;
		sType_t      sType;
		bType_t      bType;
		uType_t      uType;
		jType_t      jType;
		logic [31:0] raw;
	} instr_u;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOp_t;

	// same coding as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {sizeByte = 2'd0, sizeHalf = 2'd1, sizeWord = 2'd2} memSize_t;

	typedef enum logic [1:0] {wbAlu = 2'd0, wbLoad = 2'd1, wbPc4 = 2'd2} wbSel_t;

	typedef struct packed {
		aluOp_t   aluOp;
		logic     rfWe;
		logic     memRead;
		logic     memWrite;
		memSize_t memSize;
		logic     memUnsigned;
		logic     branch;
		logic     jump;   // jal, pc relative
		logic     jalr;   // register relative
		wbSel_t   wbSel;
	} ctrl_t;

endpackage

/* hdl/alu.sv */
module alu
	import rvPkg::*;
(
	input  logic [xlen-1:0] opA,
	input  logic [xlen-1:0] opB,
	input  aluOp_t          aluOp,
	input  logic [2:0]      funct3,   // branch condition
	output logic [xlen-1:0] aluOut,
	output logic            taken
);

	logic [4:0] shamt;
	logic       isZero;
	logic       ltS;
	logic       ltU;

	assign shamt = opB[4:0];
	assign ltS   = $signed(opA) < $signed(opB);
	assign ltU   = opA < opB;

	always_comb begin
		case (aluOp)
			aluAdd:   aluOut = opA + opB;
			aluSub:   aluOut = opA - opB;
			aluSll:   aluOut = opA << shamt;
			aluSlt:   aluOut = {{(xlen-1){1'b0}}, ltS};
			aluSltu:  aluOut = {{(xlen-1){1'b0}}, ltU};
			aluXor:   aluOut = opA ^ opB;
			aluSrl:   aluOut = opA >> shamt;
			aluSra:   aluOut = $unsigned($signed(opA) >>> shamt);
			aluOr:    aluOut = opA | opB;
			aluAnd:   aluOut = opA & opB;
			aluPassB: aluOut = opB;   // lui
			default:  aluOut = opA + opB;
		endcase
	end

	assign isZero = (aluOut == '0);

	// decoder set sub or slt/sltu, so the result bits give the outcome
	always_comb begin
		case (funct3)
			3'b000:  taken = isZero;      // beq
			3'b001:  taken = ~isZero;     // bne
			3'b100:  taken = aluOut[0];   // blt
			3'b101:  taken = ~aluOut[0];  // bge
			3'b110:  taken = aluOut[0];   // bltu
			3'b111:  taken = ~aluOut[0];  // bgeu
			default: taken = 1'b0;
		endcase
	end

endmodule

/* hdl/pcUnit.sv */
module pcUnit
	import rvPkg::*;
(
	input  logic            CLK,
	input  logic            RSTn,
	input  logic            hold,     // halted core
	input  ctrl_t           ctrl,
	input  logic            taken,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] rs1Val,
	output logic [xlen-1:0] pc
);

	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] pcRel;
	logic [xlen-1:0] regRel;
	logic [xlen-1:0] nextPc;

	assign pcPlus4 = pc + 32'd4;
	assign pcRel   = pc + imm;                        // branch and jal target
	assign regRel  = (rs1Val + imm) & ~32'd1;          // jalr drops bit 0

	always_comb begin
		if (ctrl.jalr)
			nextPc = regRel;
		else if (ctrl.jump || (ctrl.branch && taken))
			nextPc = pcRel;
		else
			nextPc = pcPlus4;  // sequential
	end

	// one instruction per edge
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
		end else if (!hold) begin
			pc <= nextPc;
		end
	end

endmodule

/* hdl/memAlign.sv */
module memAlign
	import rvPkg::*;
(
	input  ctrl_t            ctrl,
	input  logic [xlen-1:0]  addr,      // effective byte address
	input  logic [xlen-1:0]  storeVal,
	input  logic [xlen-1:0]  dMemDi,
	output logic [addrW-1:0] dMemAddr,
	output logic [xlen-1:0]  dMemDout,
	output logic [3:0]       dMemBe,
	output logic             writeReq,
	output logic [xlen-1:0]  loadVal
);

	logic [1:0]      byteOff;
	logic [3:0]      laneBe;
	logic [xlen-1:0] laneWord;   // addressed byte moved down to bit 0
	logic [7:0]      byteVal;
	logic [15:0]     halfVal;

	assign byteOff  = addr[1:0];
	assign dMemAddr = addr[addrW+1:2];  // drop byte offset
	assign writeReq = ctrl.memWrite;

	// store data replicated into every lane, enables pick the real one
	always_comb begin
		case (ctrl.memSize)
			sizeByte: begin
				dMemDout = {4{storeVal[7:0]}};
				laneBe   = 4'b0001 << byteOff;
			end
			sizeHalf: begin
				dMemDout = {2{storeVal[15:0]}};
				laneBe   = byteOff[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dMemDout = storeVal;
				laneBe   = 4'b1111;
			end
		endcase
	end

	assign dMemBe = ctrl.memWrite ? laneBe : 4'b0000;

	assign laneWord = dMemDi >> {byteOff, 3'b000};
	assign byteVal  = laneWord[7:0];
	assign halfVal  = laneWord[15:0];

	always_comb begin
		loadVal = '0;   // nothing to return outside loads
		if (ctrl.memRead) begin
			case (ctrl.memSize)
				sizeByte: loadVal = ctrl.memUnsigned ? {24'b0, byteVal}
				                                     : {{24{byteVal[7]}}, byteVal};
				sizeHalf: loadVal = ctrl.memUnsigned ? {16'b0, halfVal}
				                                     : {{16{halfVal[15]}}, halfVal};
				default:  loadVal = dMemDi;   // lw
			endcase
		end
	end

endmodule

/* hdl/instrDecode.sv */
module instrDecode
	import rvPkg::*;
(
	input  instr_u          instr,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] rfRd1,
	input  logic [xlen-1:0] rfRd2,
	output ctrl_t           ctrl,
	output logic [4:0]      rfRa1,
	output logic [4:0]      rfRa2,
	output logic [4:0]      rfWa1,
	output logic [xlen-1:0] imm,
	output logic [xlen-1:0] opA,
	output logic [xlen-1:0] opB
);

	logic [xlen-1:0] iImm;
	logic [xlen-1:0] sImm;
	logic [xlen-1:0] bImm;
	logic [xlen-1:0] uImm;
	logic [xlen-1:0] jImm;
	logic            pcA;    // opA from pc
	logic            immB;   // opB from immediate
	logic [2:0]      f3;

	// funct3 and bit 30 pick the operation, bit 30 only means sub for reg-reg
	function automatic aluOp_t decodeAlu(input logic [2:0] funct3, input logic alt,
		input logic isReg);
		aluOp_t op;
		case (funct3)
			3'b000:  op = (alt && isReg) ? aluSub : aluAdd;
			3'b001:  op = aluSll;
			3'b010:  op = aluSlt;
			3'b011:  op = aluSltu;
			3'b100:  op = aluXor;
			3'b101:  op = alt ? aluSra : aluSrl;
			3'b110:  op = aluOr;
			default: op = aluAnd;
		endcase
		return op;
	endfunction

	assign f3    = instr.rType.funct3;
	assign rfRa1 = instr.rType.rs1;
	assign rfRa2 = instr.rType.rs2;
	assign rfWa1 = instr.rType.rd;

	// immediates per format
	assign iImm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
	assign sImm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
	assign bImm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
		instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
	assign uImm = {instr.uType.imm, 12'b0};
	assign jImm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
		instr.jType.imm11, instr.jType.imm10to1, 1'b0};

	always_comb begin
		ctrl = '0;   // add, no writes, alu write-back
		imm  = iImm;
		pcA  = 1'b0;
		immB = 1'b1;
		case (instr.rType.opcode)
			opLui: begin
				ctrl.aluOp = aluPassB;
				ctrl.rfWe  = 1'b1;
				imm        = uImm;
			end
			opAuipc: begin
				ctrl.rfWe = 1'b1;
				imm       = uImm;
				pcA       = 1'b1;
			end
			opJal: begin
				ctrl.jump  = 1'b1;
				ctrl.rfWe  = 1'b1;
				ctrl.wbSel = wbPc4;
				imm        = jImm;
			end
			opJalr: begin
				ctrl.jalr  = 1'b1;
				ctrl.rfWe  = 1'b1;
				ctrl.wbSel = wbPc4;
			end
			opBranch: begin
				ctrl.branch = 1'b1;
				imm         = bImm;
				immB        = 1'b0;   // rs1 vs rs2
				case (f3[2:1])
					2'b00:   ctrl.aluOp = aluSub;    // beq bne test zero
					2'b10:   ctrl.aluOp = aluSlt;
					default: ctrl.aluOp = aluSltu;
				endcase
			end
			opLoad: begin
				ctrl.memRead     = 1'b1;
				ctrl.rfWe        = 1'b1;
				ctrl.wbSel       = wbLoad;
				ctrl.memSize     = memSize_t'(f3[1:0]);
				ctrl.memUnsigned = f3[2];   // lbu lhu
			end
			opStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.memSize  = memSize_t'(f3[1:0]);
				imm           = sImm;
			end
			opOpImm: begin
				ctrl.rfWe  = 1'b1;
				ctrl.aluOp = decodeAlu(f3, instr.rType.funct7[5], 1'b0);
			end
			opOp: begin
				ctrl.rfWe  = 1'b1;
				ctrl.aluOp = decodeAlu(f3, instr.rType.funct7[5], 1'b1);
				immB       = 1'b0;
			end
			default: ;   // unsupported opcodes act as nop
		endcase
		if (instr.rType.rd == 5'd0)
			ctrl.rfWe = 1'b0;   // x0 never written
	end

	assign opA = pcA  ? pc  : rfRd1;
	assign opB = immB ? imm : rfRd2;

endmodule

/* hdl/retireMonitor.sv */
module retireMonitor
	import rvPkg::*;
(
	input  logic            CLK,
	input  logic            RSTn,
	input  instr_u          instr,     // word retiring at the next edge
	output logic            halt,
	output logic [xlen-1:0] numInst
);

	logic prevHalt0;   // last retired word was the first halt word
	logic pairHit;

	assign pairHit = prevHalt0 && (instr.raw == haltInstr1);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			halt      <= 1'b0;
			prevHalt0 <= 1'b0;
			numInst   <= '0;
		end else if (!halt) begin
			numInst   <= numInst + 1'b1;   // second halt word still counts
			prevHalt0 <= (instr.raw == haltInstr0);
			if (pairHit)
				halt <= 1'b1;   // sticky until reset
		end
	end

endmodule

/* hdl/riscvTop.sv */
module riscvTop
	import rvPkg::*;
(
	input  logic             CLK,
	input  logic             RSTn,
	output logic             iMemCsn,
	output logic [addrW-1:0] iMemAddr,   // byte address
	input  logic [xlen-1:0]  iMemDi,
	output logic             dMemCsn,
	output logic [addrW-1:0] dMemAddr,   // word address
	output logic [xlen-1:0]  dMemDout,
	input  logic [xlen-1:0]  dMemDi,
	output logic             dMemWen,    // active low
	output logic [3:0]       dMemBe,
	output logic [4:0]       rfRa1,
	output logic [4:0]       rfRa2,
	input  logic [xlen-1:0]  rfRd1,
	input  logic [xlen-1:0]  rfRd2,
	output logic [4:0]       rfWa1,
	output logic [xlen-1:0]  rfWd,
	output logic             rfWe,
	output logic             halt,
	output logic [xlen-1:0]  numInst,
	output logic [xlen-1:0]  outputPort
);

	instr_u          instr;
	ctrl_t           ctrl;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluOut;
	logic            taken;
	logic [xlen-1:0] loadVal;
	logic [3:0]      beRaw;
	logic            writeReq;
	logic            commit;   // this cycle's writes may land

	assign instr    = iMemDi;
	assign commit   = ~RSTn & ~halt;
	assign iMemCsn  = RSTn;   // memories idle during reset
	assign dMemCsn  = RSTn;
	assign iMemAddr = pc[addrW-1:0];

	pcUnit pcUnit_i (.CLK(CLK), .RSTn(RSTn), .hold(halt), .ctrl(ctrl), .taken(taken),
		.imm(imm), .rs1Val(rfRd1), .pc(pc));

	instrDecode instrDecode_i (.instr(instr), .pc(pc), .rfRd1(rfRd1), .rfRd2(rfRd2),
		.ctrl(ctrl), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa1(rfWa1), .imm(imm),
		.opA(opA), .opB(opB));

	alu alu_i (.opA(opA), .opB(opB), .aluOp(ctrl.aluOp), .funct3(instr.rType.funct3),
		.aluOut(aluOut), .taken(taken));

	memAlign memAlign_i (.ctrl(ctrl), .addr(aluOut), .storeVal(rfRd2), .dMemDi(dMemDi),
		.dMemAddr(dMemAddr), .dMemDout(dMemDout), .dMemBe(beRaw), .writeReq(writeReq),
		.loadVal(loadVal));

	retireMonitor retireMonitor_i (.CLK(CLK), .RSTn(RSTn), .instr(instr), .halt(halt),
		.numInst(numInst));

	// write strobes blocked in reset and after halt
	assign rfWe    = ctrl.rfWe & commit;
	assign dMemWen = ~(writeReq & commit);
	assign dMemBe  = commit ? beRaw : 4'b0000;

	always_comb begin
		case (ctrl.wbSel)
			wbLoad:  rfWd = loadVal;
			wbPc4:   rfWd = pc + 32'd4;   // link value
			default: rfWd = aluOut;
		endcase
	end

	assign outputPort = rfWd;  // test observation only

endmodule

/* sim/riscvTop_asserts.sv */
module riscvTop_asserts
	import rvPkg::*;
(
	input logic             CLK,
	input logic             RSTn,
	input logic             iMemCsn,
	input logic             dMemCsn,
	input logic             dMemWen,
	input logic             rfWe,
	input logic             halt,
	input logic [3:0]       dMemBe,
	input logic [addrW-1:0] iMemAddr
);

	int failCount = 0;   // failed assertions seen by the testbench

	// memories idle and no strobes while in reset
	resetIdle: assert property (@(posedge CLK)
		RSTn |-> (iMemCsn && dMemCsn && !rfWe && dMemWen && dMemBe == 4'b0000))
		else begin
			$error("outputs active during reset");
			failCount++;
		end

	haltSticky: assert property (@(posedge CLK) disable iff (RSTn) halt |=> halt)
		else begin
			$error("halt dropped without reset");
			failCount++;
		end

	beOnlyOnWrite: assert property (@(posedge CLK) dMemWen |-> dMemBe == 4'b0000)
		else begin
			$error("byte enables set without a write");
			failCount++;
		end

	fetchAligned: assert property (@(posedge CLK) disable iff (RSTn) iMemAddr[1:0] == 2'b00)
		else begin
			$error("fetch address not word aligned");
			failCount++;
		end

endmodule

bind riscvTop riscvTop_asserts asserts_i (.CLK(CLK), .RSTn(RSTn), .iMemCsn(iMemCsn),
	.dMemCsn(dMemCsn), .dMemWen(dMemWen), .rfWe(rfWe), .halt(halt), .dMemBe(dMemBe),
	.iMemAddr(iMemAddr));

/* sim/riscvTb.sv */
module riscvTb
	import rvPkg::*;
();

	logic             CLK;
	logic             RSTn;
	logic             iMemCsn;
	logic [addrW-1:0] iMemAddr;
	logic [xlen-1:0]  iMemDi;
	logic             dMemCsn;
	logic [addrW-1:0] dMemAddr;
	logic [xlen-1:0]  dMemDout;
	logic [xlen-1:0]  dMemDi;
	logic             dMemWen;
	logic [3:0]       dMemBe;
	logic [4:0]       rfRa1;
	logic [4:0]       rfRa2;
	logic [xlen-1:0]  rfRd1;
	logic [xlen-1:0]  rfRd2;
	logic [4:0]       rfWa1;
	logic [xlen-1:0]  rfWd;
	logic             rfWe;
	logic             halt;
	logic [xlen-1:0]  numInst;
	logic [xlen-1:0]  outputPort;

	logic [xlen-1:0] imem [1024];
	logic [xlen-1:0] dmem [1024];   // 1024 words
	logic [xlen-1:0] regs [32];
	int              wrCount = 0;   // register writes seen by the model
	logic [31:0]     lfsr;
	logic [31:0]     prog [$];      // program under construction
	int              expCount;      // instructions on the predicted path
	logic [31:0]     expReg [32];
	logic [31:0]     expValid;
	int              valErrors = 0;
	int              otherErrors = 0;

	riscvTop dut_i (.*);

	always #50 CLK = ~CLK;

	// memory and register file models read combinationally and write on the edge
	assign iMemDi = iMemCsn ? '0 : imem[iMemAddr[addrW-1:2]];
	assign dMemDi = dMemCsn ? '0 : dmem[dMemAddr[9:0]];
	assign rfRd1  = (rfRa1 == 5'd0) ? '0 : regs[rfRa1];   // x0 reads zero
	assign rfRd2  = (rfRa2 == 5'd0) ? '0 : regs[rfRa2];

	always @(posedge CLK) begin
		if (!dMemCsn && !dMemWen) begin
			for (int i = 0; i < 4; i++) begin
				if (dMemBe[i])
					dmem[dMemAddr[9:0]][8*i +: 8] <= dMemDout[8*i +: 8];
			end
		end
		if (rfWe && rfWa1 != 5'd0) begin
			regs[rfWa1] <= rfWd;
			wrCount     <= wrCount + 1;
		end
	end

	// write-back mirror sampled mid cycle
	always @(negedge CLK) begin
		if (rfWe && outputPort !== rfWd) begin
			$display("[ERROR] %0t outputPort got %h expected %h", $time, outputPort, rfWd);
			valErrors++;
		end
		if (rfWe && rfWa1 == 5'd0) begin
			$display("write strobe raised for register x0 at %0t", $time);
			otherErrors++;
		end
	end

	function automatic logic nextBit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;   // galois taps 32,22,2,1
		return b;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], nextBit()};   // one step per bit
		return v;
	endfunction

	// instruction encoders
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opOp};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// rv32i result rules
	function automatic logic [31:0] refOp(input logic [2:0] f3, input bit alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic bit refBranch(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] loadRef(input logic [31:0] word, input int off,
		input logic [2:0] f3);
		logic [31:0] s;
		s = word >> (8 * off);
		case (f3)
			3'd0:    return {{24{s[7]}}, s[7:0]};
			3'd1:    return {{16{s[15]}}, s[15:0]};
			3'd4:    return {24'b0, s[7:0]};
			3'd5:    return {16'b0, s[15:0]};
			default: return word;
		endcase
	endfunction

	function automatic logic [31:0] storeRef(input logic [31:0] old, input int off,
		input logic [31:0] val, input logic [2:0] f3);
		logic [31:0] w;
		int          n;
		w = old;
		n = (f3 == 3'd0) ? 1 : ((f3 == 3'd1) ? 2 : 4);   // bytes written
		for (int i = 0; i < n; i++)
			w[8*(off+i) +: 8] = val[8*i +: 8];
		return w;
	endfunction

	function automatic logic [31:0] pcNow();
		return 32'(prog.size() * 4);   // address of the next emitted word
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			valErrors++;
		end
	endtask

	task automatic emit(input logic [31:0] word, input bit runs = 1'b1);
		prog.push_back(word);
		if (runs)
			expCount++;   // skipped words do not retire
	endtask

	task automatic setExp(input int r, input logic [31:0] v);
		expReg[r]   = v;
		expValid[r] = 1'b1;
	endtask

	task automatic loadImm(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] up;
		up = v + 32'h800;   // round the upper part since addi sign-extends
		emit(encU(up[31:12], rd, opLui));
		emit(encI(v[11:0], rd, 3'd0, rd, opOpImm));
	endtask

	task automatic prepare();
		prog.delete();
		expCount = 0;
		expValid = '0;
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = 32'(32'h9e3779b9 * (i + 1));   // hash of the word index
			imem[i] = '0;
		end
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
	endtask

	task automatic applyReset();
		@(posedge CLK);
		#5;
		RSTn = 1'b1;
		for (int i = 0; i < 8; i++) begin
			@(posedge CLK);
			#5;
			checkVal("iMemCsn", 32'(iMemCsn), 32'd1);
			checkVal("dMemCsn", 32'(dMemCsn), 32'd1);
			checkVal("rfWe", 32'(rfWe), 32'd0);
			checkVal("dMemWen", 32'(dMemWen), 32'd1);
			checkVal("numInst", numInst, 32'd0);
		end
		RSTn = 1'b0;
	endtask

	task automatic waitHalt(output bit ok);
		int n;
		n = 0;
		while (!halt && n < 500) begin
			@(posedge CLK);
			#5;
			n++;
		end
		ok = halt;
		if (!ok) begin
			$display("timeout, core did not halt within %0d cycles", n);
			otherErrors++;
		end
	endtask

	// append halt pair, run, compare registers and retire count
	task automatic runProg(output bit ok);
		emit(haltInstr0);
		emit(haltInstr1);
		foreach (prog[i])
			imem[i] = prog[i];
		applyReset();
		waitHalt(ok);
		if (ok) begin
			checkVal("numInst", numInst, 32'(expCount));
			for (int r = 0; r < 32; r++) begin
				if (expValid[r])
					checkVal($sformatf("x%0d", r), regs[r], expReg[r]);
			end
		end
	endtask

	task automatic aluTest();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] u;
		logic [31:0] opnd;
		logic [11:0] immF;
		logic [4:0]  sh;
		logic [2:0]  f3;
		bit          alt;
		bit          ok;
		int          iF3 [9];
		prepare();
		iF3  = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
		a    = randBits(32);
		b    = randBits(32);
		imm  = randBits(12);
		sh   = 5'(randBits(5));
		u    = randBits(20);
		loadImm(5'd5, a);
		loadImm(5'd6, b);
		setExp(5, a);
		setExp(6, b);
		for (int k = 0; k < 10; k++) begin   // reg-reg ops with sub and sra last
			f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
			alt = (k >= 8);
			emit(encR(alt ? 7'h20 : 7'h00, 5'd6, 5'd5, f3, 5'(10 + k)));
			setExp(10 + k, refOp(f3, alt, a, b));
		end
		for (int k = 0; k < 9; k++) begin
			f3  = 3'(iF3[k]);
			alt = (k == 8);
			if (f3 == 3'd1 || f3 == 3'd5) begin
				immF = {alt ? 7'h20 : 7'h00, sh};   // shamt form
				opnd = {27'b0, sh};
			end else begin
				immF = imm[11:0];
				opnd = {{20{imm[11]}}, imm[11:0]};
			end
			emit(encI(immF, 5'd5, f3, 5'(20 + k), opOpImm));
			setExp(20 + k, refOp(f3, alt, a, opnd));
		end
		emit(encR(7'h00, 5'd6, 5'd5, 3'd0, 5'd0));    // result dropped
		emit(encR(7'h00, 5'd5, 5'd0, 3'd0, 5'd29));   // x0 + a
		setExp(29, a);
		emit(encU(u[19:0], 5'd30, opLui));
		setExp(30, {u[19:0], 12'b0});
		setExp(31, pcNow() + {u[19:0], 12'b0});
		emit(encU(u[19:0], 5'd31, opAuipc));
		runProg(ok);
	endtask

	task automatic memTest();
		logic [31:0] v6;
		logic [31:0] v7;
		logic [31:0] expMem [1024];
		int          stF3 [7];
		int          stRs [7];
		int          stOff [7];
		int          wi;
		bit          ok;
		prepare();
		dmem[80] = 32'h80f17f91;   // byte 320 with mixed signs in bytes and halves
		foreach (dmem[i])
			expMem[i] = dmem[i];
		stF3  = '{2, 1, 1, 0, 0, 0, 0};
		stRs  = '{6, 6, 7, 6, 7, 6, 7};
		stOff = '{0, 4, 10, 16, 21, 26, 31};
		v6    = randBits(32);
		v7    = randBits(32);
		emit(encI(12'd256, 5'd0, 3'd0, 5'd5, opOpImm));   // base
		loadImm(5'd6, v6);
		loadImm(5'd7, v7);
		setExp(5, 32'd256);
		setExp(6, v6);
		setExp(7, v7);
		for (int k = 0; k < 4; k++) begin
			emit(encI(12'(64 + k), 5'd5, 3'd0, 5'(10 + k), opLoad));   // lb
			setExp(10 + k, loadRef(dmem[80], k, 3'd0));
			emit(encI(12'(64 + k), 5'd5, 3'd4, 5'(14 + k), opLoad));   // lbu
			setExp(14 + k, loadRef(dmem[80], k, 3'd4));
		end
		for (int k = 0; k < 2; k++) begin
			emit(encI(12'(64 + 2 * k), 5'd5, 3'd1, 5'(18 + k), opLoad));
			setExp(18 + k, loadRef(dmem[80], 2 * k, 3'd1));
			emit(encI(12'(64 + 2 * k), 5'd5, 3'd5, 5'(20 + k), opLoad));
			setExp(20 + k, loadRef(dmem[80], 2 * k, 3'd5));
		end
		emit(encI(12'd64, 5'd5, 3'd2, 5'd22, opLoad));
		setExp(22, dmem[80]);
		// sw, two sh, sb on every lane
		for (int k = 0; k < 7; k++) begin
			emit(encS(12'(stOff[k]), 5'(stRs[k]), 5'd5, 3'(stF3[k])));
			wi = 64 + stOff[k] / 4;
			expMem[wi] = storeRef(expMem[wi], stOff[k] % 4, (stRs[k] == 6) ? v6 : v7,
				3'(stF3[k]));
		end
		emit(encI(12'd0, 5'd5, 3'd2, 5'd23, opLoad));    // read back stores
		setExp(23, loadRef(expMem[64], 0, 3'd2));
		emit(encI(12'd10, 5'd5, 3'd5, 5'd24, opLoad));
		setExp(24, loadRef(expMem[66], 2, 3'd5));
		runProg(ok);
		if (ok) begin
			for (int i = 60; i < 84; i++)
				checkVal($sformatf("dmem[%0d]", i), dmem[i], expMem[i]);
		end
	endtask

	task automatic branchTest();
		logic [31:0] val [8];
		logic [31:0] p;
		logic [2:0]  f3;
		int          brF3 [6];
		int          ra [12];
		int          rb [12];
		bit          tk;
		bit          ok;
		prepare();
		brF3   = '{0, 1, 4, 5, 6, 7};
		ra     = '{6, 5, 5, 6, 5, 6, 6, 5, 6, 5, 5, 6};   // taken case first per kind
		rb     = '{7, 6, 6, 7, 6, 5, 5, 6, 5, 6, 6, 5};
		val[5] = 32'hfffffffd;
		val[6] = 32'd4;
		val[7] = 32'd4;
		emit(encI(12'hffd, 5'd0, 3'd0, 5'd5, opOpImm));
		emit(encI(12'd4, 5'd0, 3'd0, 5'd6, opOpImm));
		emit(encI(12'd4, 5'd0, 3'd0, 5'd7, opOpImm));
		for (int r = 5; r < 8; r++)
			setExp(r, val[r]);
		for (int k = 0; k < 12; k++) begin
			f3 = 3'(brF3[k / 2]);
			tk = refBranch(f3, val[ra[k]], val[rb[k]]);
			emit(encB(13'd8, 5'(rb[k]), 5'(ra[k]), f3));
			emit(encI(12'd1, 5'd0, 3'd0, 5'(10 + k), opOpImm), !tk);   // marker
			setExp(10 + k, tk ? 32'd0 : 32'd1);
		end
		p = pcNow();
		emit(encJ(21'd8, 5'd22));
		emit(encI(12'd1, 5'd0, 3'd0, 5'd23, opOpImm), 1'b0);
		setExp(22, p + 32'd4);
		setExp(23, 32'd0);
		p = pcNow();
		emit(encU(20'd0, 5'd24, opAuipc));
		emit(encI(12'd13, 5'd24, 3'd0, 5'd25, opJalr));   // odd target with bit 0 dropped
		emit(encI(12'd1, 5'd0, 3'd0, 5'd26, opOpImm), 1'b0);
		setExp(24, p);
		setExp(25, p + 32'd8);
		setExp(26, 32'd0);
		runProg(ok);
	endtask

	task automatic haltTest();
		int wr0;
		bit ok;
		prepare();
		emit(haltInstr0);                                // x1 = 12
		emit(encI(12'd5, 5'd0, 3'd0, 5'd2, opOpImm));   // splits the pair
		emit(haltInstr1);                                // jumps to 12 without halting
		emit(encI(12'd7, 5'd0, 3'd0, 5'd3, opOpImm));
		setExp(1, 32'd12);
		setExp(2, 32'd5);
		setExp(3, 32'd7);
		runProg(ok);
		if (ok) begin
			wr0 = wrCount;
			for (int i = 0; i < 20; i++) begin
				@(posedge CLK);
				#5;
				checkVal("iMemAddr", 32'(iMemAddr), 32'd12);
				checkVal("rfWe", 32'(rfWe), 32'd0);
				checkVal("numInst", numInst, 32'd6);
			end
			checkVal("regWrites", 32'(wrCount), 32'(wr0));
		end
	endtask

	initial begin
		CLK  = 1'b0;
		RSTn = 1'b1;
		lfsr = 32'he9a0;
		aluTest();
		memTest();
		branchTest();
		haltTest();
		$display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
			valErrors, otherErrors, dut_i.asserts_i.failCount);
		if (valErrors == 0 && otherErrors == 0 && dut_i.asserts_i.failCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* all.f */
hdl/rvPkg.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/memAlign.sv
hdl/instrDecode.sv
hdl/retireMonitor.sv
hdl/riscvTop.sv
sim/riscvTop_asserts.sv
sim/riscvTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= riscvTb
LOG       ?= sim.log
SEED      ?= 1
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f all.f

run: compile
	$(OBJDIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
